/* mod_reduce_cfg.svh */
`ifndef MOD_REDUCE_CFG_SVH
`define MOD_REDUCE_CFG_SVH

// Modulus and operand geometry.
`define MOD_VALUE       4051
`define OPERAND_WIDTH   400
`define CHUNK_WIDTH     6
`define NUM_CHUNKS      67

// Residue and product widths.
`define RESIDUE_WIDTH   12
`define WIDE_WIDTH      18

// 4096 mod 4051 = 45, so bits above 12 fold back with weight 45.
`define FOLD_SHIFT      12
`define FOLD_FACTOR     45

`endif

/* mod_reduce_pkg.sv */
`default_nettype none

`include "mod_reduce_cfg.svh"

package mod_reduce_pkg;

  // Full operand and one slice of it.
  typedef logic [`OPERAND_WIDTH-1:0] operand_t;
  typedef logic [`CHUNK_WIDTH-1:0]   chunk_t;

  // Residue below the modulus.
  typedef logic [`RESIDUE_WIDTH-1:0] residue_t;

  // Unfolded product, chunk times weight or weight times 64.
  typedef logic [`WIDE_WIDTH-1:0]    wide_t;

  // Step counter, wide enough for all chunks.
  typedef logic [$clog2(`NUM_CHUNKS)-1:0] chunk_idx_t;

  // Controller states.
  typedef enum logic [1:0]
  {
    st_idle,
    st_load,
    st_run,
    st_done
  } ctrl_state_t;

endpackage

`default_nettype wire

/* fold_reduce.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mod_reduce_cfg.svh"

module fold_reduce
(
  input  mod_reduce_pkg::wide_t    wide_value,
  output mod_reduce_pkg::residue_t residue
);

  import mod_reduce_pkg::*;

  residue_t                           fold_lo;
  logic [`WIDE_WIDTH-`FOLD_SHIFT-1:0] fold_hi;
  logic [`RESIDUE_WIDTH:0]            fold_sum;

  assign fold_lo = wide_value[`FOLD_SHIFT-1:0];
  assign fold_hi = wide_value[`WIDE_WIDTH-1:`FOLD_SHIFT];

  // 4096 = 45 mod 4051. Sum stays under 2 * 4051.
  assign fold_sum = (`RESIDUE_WIDTH+1)'(fold_lo)
                  + (`RESIDUE_WIDTH+1)'(fold_hi) * (`RESIDUE_WIDTH+1)'(`FOLD_FACTOR);

  assign residue = (fold_sum >= `MOD_VALUE) ? residue_t'(fold_sum - `MOD_VALUE)
                                            : residue_t'(fold_sum);

endmodule

`default_nettype wire

/* operand_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mod_reduce_cfg.svh"

module operand_shifter
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     load,
  input  logic                     step,
  input  mod_reduce_pkg::operand_t operand,
  output mod_reduce_pkg::chunk_t   chunk
);

  import mod_reduce_pkg::*;

  operand_t shift_reg;

  // Lowest chunk first, zeros come in from the top.
  always_ff @(posedge clk)
  begin
    if (reset)
      shift_reg <= '0;
    else if (load)
      shift_reg <= operand;
    else if (step)
      shift_reg <= shift_reg >> `CHUNK_WIDTH;
  end

  // Top chunk has only 4 live bits.
  assign chunk = shift_reg[`CHUNK_WIDTH-1:0];

endmodule

`default_nettype wire

/* weight_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mod_reduce_cfg.svh"

module weight_gen
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     load,
  input  logic                     step,
  output mod_reduce_pkg::residue_t weight
);

  import mod_reduce_pkg::*;

  wide_t    weight_x64;
  residue_t weight_next;

  // Times 2^6 is a plain shift, fits in 18 bits.
  assign weight_x64 = {weight, {`CHUNK_WIDTH{1'b0}}};

  fold_reduce u_fold_weight
  (
    .wide_value (weight_x64),
    .residue    (weight_next)
  );

  // Weight of chunk i is 2^(6i) mod 4051.
  always_ff @(posedge clk)
  begin
    if (reset || load)
      weight <= residue_t'(1);
    else if (step)
      weight <= weight_next;
  end

endmodule

`default_nettype wire

/* term_accum.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mod_reduce_cfg.svh"

module term_accum
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     load,
  input  logic                     step,
  input  mod_reduce_pkg::chunk_t   chunk,
  input  mod_reduce_pkg::residue_t weight,
  output mod_reduce_pkg::residue_t result
);

  import mod_reduce_pkg::*;

  wide_t                   product;
  residue_t                term;
  logic [`RESIDUE_WIDTH:0] acc_sum;
  residue_t                acc_next;

  // At most 63 * 4050, still inside 18 bits.
  assign product = wide_t'(chunk) * wide_t'(weight);

  fold_reduce u_fold_term
  (
    .wide_value (product),
    .residue    (term)
  );

  // ##############################
  // Accumulator
  // ##############################

  assign acc_sum  = {1'b0, result} + {1'b0, term};
  assign acc_next = (acc_sum >= `MOD_VALUE) ? residue_t'(acc_sum - `MOD_VALUE)
                                            : residue_t'(acc_sum);

  always_ff @(posedge clk)
  begin
    if (reset || load)
      result <= '0;
    else if (step)
      result <= acc_next;   // Holds between runs.
  end

endmodule

`default_nettype wire

/* reduce_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mod_reduce_cfg.svh"

module reduce_ctrl
(
  input  logic clk,
  input  logic reset,
  input  logic req,
  output logic ack,
  output logic load,
  output logic step
);

  import mod_reduce_pkg::*;

  localparam chunk_idx_t last_idx = chunk_idx_t'(`NUM_CHUNKS - 1);

  ctrl_state_t state;
  ctrl_state_t state_next;
  chunk_idx_t  chunk_idx;

  // ##############################
  // State machine
  // ##############################

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= st_idle;
    else
      state <= state_next;
  end

  always_comb
  begin
    state_next = state;
    case (state)
      st_idle:
      begin
        if (req)
          state_next = st_load;
      end
      st_load:
      begin
        state_next = st_run;
      end
      st_run:
      begin
        if (chunk_idx == last_idx)
          state_next = st_done;   // Last chunk taken this cycle.
      end
      st_done:
      begin
        if (!req)
          state_next = st_idle;   // Hold until req drops.
      end
      default:
      begin
        state_next = st_idle;
      end
    endcase
  end

  // Counts run cycles, restarts from zero on every entry to run.
  always_ff @(posedge clk)
  begin
    if (reset || state != st_run)
      chunk_idx <= '0;
    else
      chunk_idx <= chunk_idx + 1'b1;
  end

  // ##############################
  // Outputs
  // ##############################

  assign load = (state == st_load);
  assign step = (state == st_run);

  // Registered, follows done by one cycle.
  always_ff @(posedge clk)
  begin
    if (reset)
      ack <= 1'b0;
    else
      ack <= (state == st_done);
  end

endmodule

`default_nettype wire

/* mod_reduce_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mod_reduce_top
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     req,
  input  mod_reduce_pkg::operand_t operand,
  output logic                     ack,
  output mod_reduce_pkg::residue_t result
);

  import mod_reduce_pkg::*;

  logic     load;   // One cycle, starts a reduction.
  logic     step;   // One chunk per cycle.
  chunk_t   chunk;
  residue_t weight;

  // ##############################
  // Control
  // ##############################

  reduce_ctrl u_ctrl
  (
    .clk   (clk),
    .reset (reset),
    .req   (req),
    .ack   (ack),
    .load  (load),
    .step  (step)
  );

  // ##############################
  // Datapath
  // ##############################

  operand_shifter u_shifter
  (
    .clk     (clk),
    .reset   (reset),
    .load    (load),
    .step    (step),
    .operand (operand),
    .chunk   (chunk)
  );

  weight_gen u_weight
  (
    .clk    (clk),
    .reset  (reset),
    .load   (load),
    .step   (step),
    .weight (weight)
  );

  // Chunk and weight line up, both advance on step.
  term_accum u_accum
  (
    .clk    (clk),
    .reset  (reset),
    .load   (load),
    .step   (step),
    .chunk  (chunk),
    .weight (weight),
    .result (result)
  );

endmodule

`default_nettype wire

/* tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock
#(
  parameter real period_ns = 20.0
)
(
  output logic clk
);

  // Free running, starts low.
  initial
  begin
    clk = 1'b0;
    forever
      #(period_ns / 2.0) clk = ~clk;
  end

endmodule

`default_nettype wire

/* tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mod_reduce_cfg.svh"

module tb_top;

  import mod_reduce_pkg::*;

  localparam int max_vectors  = 32;
  localparam int max_delay    = 8;    // Random delays run 0 to 7 cycles.
  localparam int txn_cycles   = 69;   // req sampled high to ack high.
  localparam int reset_cycles = 5;

  logic     clk;
  logic     reset;
  logic     req;
  operand_t operand;
  logic     ack;
  residue_t result;

  // Even words hold operands, odd words the expected residues.
  operand_t vec_mem [0:2*max_vectors-1];

  int       num_vectors;
  int       cycle_count = 0;
  int       cycle_limit = 1000;
  integer   seed;

  // ##############################
  // Clock and DUT
  // ##############################

  tb_clock #(.period_ns (20.0)) u_clock
  (
    .clk (clk)
  );

  mod_reduce_top DUT
  (
    .clk     (clk),
    .reset   (reset),
    .req     (req),
    .operand (operand),
    .ack     (ack),
    .result  (result)
  );

  // ##############################
  // Helpers
  // ##############################

  task automatic fail_run(input string msg);
  begin
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "Run stopped at the first error.");
  end
  endtask

  task automatic load_vectors();
    int addr;
  begin
    // Fill words are never below the modulus.
    for (addr = 0; addr < 2 * max_vectors; addr++)
      vec_mem[addr] = ~operand_t'(addr);
    $readmemh("reduce_input.txt", vec_mem);
    num_vectors = 0;
    while (num_vectors < max_vectors &&
           vec_mem[2 * num_vectors + 1] < operand_t'(`MOD_VALUE))
      num_vectors++;
  end
  endtask

  task automatic check_idle();
  begin
    assert (ack === 1'b0)
    else
      fail_run($sformatf("FAIL: ack = %h after reset, expected 0", ack));
    assert (result === '0)
    else
      fail_run($sformatf("FAIL: result = %h after reset, expected 000", result));
  end
  endtask

  // Starts and ends on a falling edge with ack low.
  task automatic run_transaction(input int idx, input operand_t op, input residue_t expected);
    int hold_cycles;
  begin
    operand = op;
    req     = 1'b1;
    @(negedge clk);
    while (ack !== 1'b1)
      @(negedge clk);
    assert (result === expected)
    else
      fail_run($sformatf("FAIL: vector %0d result = %h, expected %h",
                         idx, result, expected));

    // Back-pressure.
    hold_cycles = $random(seed) & (max_delay - 1);
    repeat (hold_cycles)
    begin
      @(negedge clk);
      assert (ack === 1'b1)
      else
        fail_run($sformatf("FAIL: vector %0d ack = %h with req held, expected 1",
                           idx, ack));
      assert (result === expected)
      else
        fail_run($sformatf("FAIL: vector %0d result = %h with req held, expected %h",
                           idx, result, expected));
    end

    req = 1'b0;
    while (ack !== 1'b0)
      @(negedge clk);
    assert (result === expected)
    else
      fail_run($sformatf("FAIL: vector %0d result = %h after release, expected %h",
                         idx, result, expected));
    operand = ~op;   // Not sampled while idle.
  end
  endtask

  // ##############################
  // Timeout
  // ##############################

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    assert (cycle_count < cycle_limit)
    else
      fail_run($sformatf("Timeout: the run did not finish within %0d clock cycles",
                         cycle_limit));
  end

  // ##############################
  // Stimulus
  // ##############################

  initial
  begin
    int       idx;
    int       gap;
    operand_t op;
    residue_t expected;

    seed    = 8;
    reset   = 1'b1;
    req     = 1'b0;
    operand = '0;

    load_vectors();
    assert (num_vectors > 0)
    else
      fail_run("No test vectors could be read from reduce_input.txt");
    cycle_limit = num_vectors * (txn_cycles + 2 * max_delay) + 100;

    repeat (reset_cycles)
      @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // No request yet.
    repeat (2)
    begin
      @(negedge clk);
      check_idle();
    end

    for (idx = 0; idx < num_vectors; idx++)
    begin
      op       = vec_mem[2 * idx];
      expected = residue_t'(vec_mem[2 * idx + 1]);
      run_transaction(idx, op, expected);
      gap = $random(seed) & (max_delay - 1);
      repeat (gap)
        @(negedge clk);
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

/* reduce_input.txt */
// Column 1: 400-bit operand in hex, leading zeros left out.
// Column 2: expected residue, operand mod 4051, in hex.

// Edge operands.
0 0
FD3 0
FD2 FD2
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF 0

// Small values near multiples of the modulus.
1 1
FD4 1
1FA5 FD2
1000 2D
100000000 F53

// Single and mixed 100-bit blocks.
0123456789ABCDEF013579BDF B45
FEDCBA9876543210FDB975310 AEC
0123456789ABCDEF013579BDFFEDCBA9876543210FDB975310 65E

// Full width patterns.
0123456789ABCDEF013579BDF0123456789ABCDEF013579BDF0123456789ABCDEF013579BDF0123456789ABCDEF013579BDF D6E
FEDCBA9876543210FDB975310FEDCBA9876543210FDB975310FEDCBA9876543210FDB975310FEDCBA9876543210FDB975310 C0A
FEDCBA9876543210FDB9753100123456789ABCDEF013579BDFFEDCBA9876543210FDB9753100123456789ABCDEF013579BDF CBC
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFE FD2
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF000 FA7
7FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF 7E9

/* tb.f */
+incdir+.
mod_reduce_pkg.sv
fold_reduce.sv
operand_shifter.sv
weight_gen.sv
term_accum.sv
reduce_ctrl.sv
mod_reduce_top.sv
tb_clock.sv
tb_top.sv
